/* common/fp_convert_pkg.sv */
package fp_convert_pkg;

    ////////////////////////////////////////
    // format widths and biases
    ////////////////////////////////////////
    localparam int IN_EXP_W   = 8;                        // fp32 exponent
    localparam int IN_FRAC_W  = 23;                       // fp32 fraction, no hidden one
    localparam int OUT_EXP_W  = 5;                        // fp16 exponent
    localparam int OUT_FRAC_W = 10;                       // fp16 fraction, no hidden one
    localparam int IN_BIAS    = 127;
    localparam int OUT_BIAS   = 15;
    localparam int DROP_W     = IN_FRAC_W - OUT_FRAC_W;   // bits lost by rounding

    localparam logic [OUT_FRAC_W-1:0] QNAN_FRAC = {1'b1, {(OUT_FRAC_W-1){1'b0}}};

    ////////////////////////////////////////
    // word formats
    ////////////////////////////////////////
    typedef struct packed {
        logic                 sign;
        logic [IN_EXP_W-1:0]  exp;
        logic [IN_FRAC_W-1:0] frac;
    } fp32_t;

    typedef struct packed {
        logic                  sign;
        logic [OUT_EXP_W-1:0]  exp;
        logic [OUT_FRAC_W-1:0] frac;
    } fp16_t;

    ////////////////////////////////////////
    // stage-1 bundles
    ////////////////////////////////////////
    typedef struct packed {
        logic zero;
        logic denorm;
        logic inf;
        logic nan;
    } fp_class_t;

    typedef struct packed {
        logic                valid;
        logic                sign;                        // already cleared for nan
        logic [IN_EXP_W-1:0] exp;                         // biased input exponent
        fp_class_t           cls;
    } class_bundle_t;

    typedef struct packed {
        logic [OUT_FRAC_W-1:0] mant;                      // rounded fraction
        logic                  carry;                     // rounding overflowed the fraction
    } round_bundle_t;

endpackage

/* dv/tb_clk_gen.sv */
module tb_clk_gen (
    output logic o_aclk,
    output logic o_areset_n
);

    timeunit 1ns;
    timeprecision 100ps;

    ////////////////////////////////////////
    // 8 ns clock, reset for two cycles
    ////////////////////////////////////////
    initial begin
        o_aclk = 1'b0;
        forever #4 o_aclk = ~o_aclk;
    end

    initial begin
        o_areset_n = 1'b0;
        repeat (2) @(posedge o_aclk);
        o_areset_n <= 1'b1;                               // released on a rising edge
    end

endmodule

/* dv/tb_fp32_to_fp16.sv */
module tb_fp32_to_fp16;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 200;

    logic                  aclk;
    logic                  areset_n;
    logic                  aclken;
    logic                  in_valid;
    fp_convert_pkg::fp32_t in_data;
    logic                  out_valid;
    fp_convert_pkg::fp16_t out_data;
    logic                  overflow;
    logic                  underflow;

    logic [31:0] in_q[$];
    logic [17:0] exp_q[$];                                // {ovf, unf, fp16}
    logic [17:0] got_q[$];
    logic        en_seen = 1'b0;
    integer      seed;
    int          n_tests;
    int          n_checks;
    int          n_errors;

    tb_clk_gen u_clk_gen (
        .o_aclk     (aclk),
        .o_areset_n (areset_n)
    );

    fp32_to_fp16 dut (
        .i_aclk      (aclk),
        .i_areset_n  (areset_n),
        .i_aclken    (aclken),
        .i_valid     (in_valid),
        .i_data      (in_data),
        .o_valid     (out_valid),
        .o_data      (out_data),
        .o_overflow  (overflow),
        .o_underflow (underflow)
    );

    // one entry per enabled edge that produced a result
    always @(negedge aclk) begin
        if (en_seen && out_valid) begin
            got_q.push_back({overflow, underflow, out_data});
        end
        en_seen = aclken;                                 // enable the next edge will use
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////
    function automatic logic [17:0] expected_fp16(input logic [31:0] x);
        logic s;
        int   e;
        int   f;
        int   kept;
        int   rem;
        int   reb;
        s = x[31];
        e = x[30:23];
        f = x[22:0];
        if (e == 255) begin
            if (f != 0) return {2'b00, 16'h7e00};
            return {2'b00, s, 5'h1f, 10'h000};
        end
        if (e == 0) begin
            if (f == 0) return {2'b00, s, 15'h0000};
            return {2'b01, s, 15'h0000};                  // denormal input
        end
        kept = f / 8192;
        rem  = f % 8192;
        if (rem > 4096 || (rem == 4096 && kept % 2 == 1)) kept++;
        reb = e - fp_convert_pkg::IN_BIAS + fp_convert_pkg::OUT_BIAS;
        if (reb <= 0) return {2'b01, s, 15'h0000};
        if (kept == 1024) begin                           // mantissa carry
            kept = 0;
            reb++;
        end
        if (reb >= 31) return {2'b10, s, 5'h1f, 10'h000};
        return {2'b00, s, reb[4:0], kept[9:0]};
    endfunction

    function automatic logic [31:0] random_normal();
        logic [31:0] w;
        w        = $random(seed);
        w[30:23] = 8'(100 + ({$random(seed)} % 50));      // straddles both range edges
        return w;
    endfunction

    ////////////////////////////////////////
    // drivers and checker
    ////////////////////////////////////////
    task automatic drive_item(input logic [31:0] w);
        @(posedge aclk);
        in_valid <= 1'b1;
        in_data  <= w;
        aclken   <= 1'b1;
        in_q.push_back(w);
        exp_q.push_back(expected_fp16(w));
    endtask

    task automatic freeze(input int n);
        repeat (n) begin
            @(posedge aclk);
            aclken <= 1'b0;
        end
    endtask

    task automatic go_idle();
        @(posedge aclk);
        in_valid <= 1'b0;
        aclken   <= 1'b1;
    endtask

    task automatic collect_and_check(input string name);
        int          cycles;
        logic [31:0] w;
        logic [17:0] e;
        logic [17:0] g;
        cycles = 0;
        while (got_q.size() < exp_q.size() && cycles < WAIT_LIMIT) begin
            @(posedge aclk);
            cycles++;
        end
        if (got_q.size() < exp_q.size()) begin
            $display("%s: timed out waiting for o_valid, got %0d of %0d results",
                     name, got_q.size(), exp_q.size());
            n_errors++;
        end
        while (got_q.size() > 0 && exp_q.size() > 0) begin
            w = in_q.pop_front();
            e = exp_q.pop_front();
            g = got_q.pop_front();
            n_checks++;
            if (g !== e) begin
                $display("FAILED %s: in %h expected %h ovf %b unf %b, actual %h ovf %b unf %b",
                         name, w, e[15:0], e[17], e[16], g[15:0], g[17], g[16]);
                n_errors++;
            end
        end
        if (got_q.size() > 0) begin
            $display("%s: %0d results arrived that were never sent", name, got_q.size());
            n_errors++;
        end
        in_q.delete();
        exp_q.delete();
        got_q.delete();
    endtask

    task automatic report_test(input string name, input int chk0, input int err0);
        n_tests++;
        $display("%-10s done, %0d checks, %0d failed", name, n_checks - chk0, n_errors - err0);
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////
    task automatic test_exact();
        int chk0;
        int err0;
        int cycles;
        chk0   = n_checks;
        err0   = n_errors;
        cycles = 0;
        while (areset_n !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(posedge aclk);
            cycles++;
        end
        if (areset_n !== 1'b1) begin
            $display("exact: reset was never released");
            n_errors++;
        end
        @(negedge aclk);
        n_checks++;
        if ({out_valid, out_data, overflow, underflow} !== '0) begin
            $display("FAILED exact: after reset expected %h actual %h", 19'h0,
                     {out_valid, out_data, overflow, underflow});
            n_errors++;
        end
        drive_item(32'h3f80_0000);                        // 1.0
        go_idle();
        collect_and_check("exact");
        drive_item(32'hc020_0000);                        // -2.5
        drive_item(32'h477f_e000);                        // 65504
        drive_item(32'h3f00_0000);
        go_idle();
        collect_and_check("exact");
        report_test("exact", chk0, err0);
    endtask

    task automatic test_rounding();
        int chk0;
        int err0;
        chk0 = n_checks;
        err0 = n_errors;
        drive_item(32'h3f80_0fff);                        // below half
        drive_item(32'h3f80_1001);                        // above half
        drive_item(32'h3f80_1000);                        // tie with even lsb stays
        drive_item(32'h3f80_3000);                        // tie with odd lsb rounds up
        drive_item(32'h3fff_f000);                        // all ones carries into exponent
        drive_item(32'hbfff_ffff);
        go_idle();
        collect_and_check("rounding");
        report_test("rounding", chk0, err0);
    endtask

    task automatic test_specials();
        int chk0;
        int err0;
        chk0 = n_checks;
        err0 = n_errors;
        drive_item(32'h0000_0000);
        drive_item(32'h8000_0000);
        drive_item(32'h7f80_0000);
        drive_item(32'hff80_0000);
        drive_item(32'h7fc0_0000);
        drive_item(32'hff80_0001);                        // negative nan
        drive_item(32'h0000_0001);
        drive_item(32'h807f_ffff);
        go_idle();
        collect_and_check("specials");
        report_test("specials", chk0, err0);
    endtask

    task automatic test_range();
        int chk0;
        int err0;
        chk0 = n_checks;
        err0 = n_errors;
        drive_item(32'h4780_0000);                        // 65536
        drive_item(32'hc780_0000);
        drive_item(32'h477f_f000);                        // carry into exponent 31
        drive_item(32'h3880_0000);                        // smallest fp16 normal
        drive_item(32'h3800_0000);
        drive_item(32'hb380_0000);
        go_idle();
        collect_and_check("range");
        report_test("range", chk0, err0);
    endtask

    task automatic test_pipeline();
        int chk0;
        int err0;
        chk0 = n_checks;
        err0 = n_errors;
        repeat (24) drive_item(random_normal());
        go_idle();
        collect_and_check("pipeline");
        report_test("pipeline", chk0, err0);
    endtask

    task automatic test_enable();
        int chk0;
        int err0;
        chk0 = n_checks;
        err0 = n_errors;
        repeat (4) drive_item(random_normal());
        freeze(2);                                        // two items in flight
        repeat (5) drive_item(random_normal());
        freeze(3);
        repeat (4) drive_item(random_normal());
        go_idle();
        collect_and_check("enable");
        report_test("enable", chk0, err0);
    endtask

    initial begin
        in_valid = 1'b0;
        in_data  = '0;
        aclken   = 1'b1;
        seed     = 32'hedfb;
        n_tests  = 0;
        n_checks = 0;
        n_errors = 0;
        test_exact();
        test_rounding();
        test_specials();
        test_range();
        test_pipeline();
        test_enable();
        $display("summary: %0d tests, %0d checks, %0d failures", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* fp_convert/fp32_to_fp16.sv */
module fp32_to_fp16 (
    input  logic                  i_aclk,
    input  logic                  i_areset_n,
    input  logic                  i_aclken,
    input  logic                  i_valid,
    input  fp_convert_pkg::fp32_t i_data,
    output logic                  o_valid,
    output fp_convert_pkg::fp16_t o_data,
    output logic                  o_overflow,
    output logic                  o_underflow
);

    fp_convert_pkg::class_bundle_t s1_class;
    fp_convert_pkg::round_bundle_t s1_round;

    ////////////////////////////////////////
    // stage 1, both blocks see the same word
    ////////////////////////////////////////
    fp_class_decode u_class_decode (
        .i_aclk     (i_aclk),
        .i_areset_n (i_areset_n),
        .i_aclken   (i_aclken),
        .i_valid    (i_valid),
        .i_data     (i_data),
        .o_class    (s1_class)
    );

    fp_mant_round u_mant_round (
        .i_aclk     (i_aclk),
        .i_areset_n (i_areset_n),
        .i_aclken   (i_aclken),
        .i_valid    (i_valid),
        .i_frac     (i_data.frac),
        .o_round    (s1_round)
    );

    ////////////////////////////////////////
    // stage 2
    ////////////////////////////////////////
    fp_result_pack u_result_pack (
        .i_aclk      (i_aclk),
        .i_areset_n  (i_areset_n),
        .i_aclken    (i_aclken),
        .i_class     (s1_class),
        .i_round     (s1_round),
        .o_valid     (o_valid),
        .o_data      (o_data),
        .o_overflow  (o_overflow),
        .o_underflow (o_underflow)
    );

endmodule

/* fp_convert/fp_class_decode.sv */
module fp_class_decode (
    input  logic                          i_aclk,
    input  logic                          i_areset_n,
    input  logic                          i_aclken,
    input  logic                          i_valid,
    input  fp_convert_pkg::fp32_t         i_data,
    output fp_convert_pkg::class_bundle_t o_class
);

    logic                      exp_zero;
    logic                      exp_ones;
    logic                      frac_zero;
    fp_convert_pkg::fp_class_t cls_d;

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////
    always_comb begin
        exp_zero  = (i_data.exp == '0);
        exp_ones  = (i_data.exp == '1);
        frac_zero = (i_data.frac == '0);

        cls_d.zero   = exp_zero & frac_zero;
        cls_d.denorm = exp_zero & ~frac_zero;
        cls_d.inf    = exp_ones & frac_zero;
        cls_d.nan    = exp_ones & ~frac_zero;
    end

    ////////////////////////////////////////
    // stage-1 register
    ////////////////////////////////////////
    always_ff @(posedge i_aclk or negedge i_areset_n) begin
        if (!i_areset_n) begin
            o_class <= '0;
        end else if (i_aclken) begin
            o_class.valid <= i_valid;                     // valid moves every enabled edge
            if (i_valid) begin
                o_class.sign <= i_data.sign & ~cls_d.nan; // nan comes out positive
                o_class.exp  <= i_data.exp;
                o_class.cls  <= cls_d;
            end
        end
    end

    // the class flags feed a priority mux downstream, two at once would be ambiguous
    a_class_onehot : assert property (
        @(posedge i_aclk) disable iff (!i_areset_n)
        $onehot0(o_class.cls)
    ) else $error("fp_class_decode: more than one class flag set");

endmodule

/* fp_convert/fp_mant_round.sv */
module fp_mant_round (
    input  logic                                 i_aclk,
    input  logic                                 i_areset_n,
    input  logic                                 i_aclken,
    input  logic                                 i_valid,
    input  logic [fp_convert_pkg::IN_FRAC_W-1:0] i_frac,
    output fp_convert_pkg::round_bundle_t        o_round
);

    logic [fp_convert_pkg::OUT_FRAC_W-1:0] kept;
    logic                                  guard;
    logic                                  sticky;
    logic                                  lsb;
    logic                                  round_up;
    logic [fp_convert_pkg::OUT_FRAC_W:0]   sum;

    ////////////////////////////////////////
    // round to nearest, ties to even
    ////////////////////////////////////////
    always_comb begin
        kept   = i_frac[fp_convert_pkg::IN_FRAC_W-1 -: fp_convert_pkg::OUT_FRAC_W];
        guard  = i_frac[fp_convert_pkg::DROP_W-1];          // first dropped bit
        sticky = |i_frac[fp_convert_pkg::DROP_W-2:0];       // anything below guard
        lsb    = i_frac[fp_convert_pkg::DROP_W];            // kept lsb for the tie case

        round_up = guard & (sticky | lsb);
        sum      = {1'b0, kept} + {{fp_convert_pkg::OUT_FRAC_W{1'b0}}, round_up};
    end

    ////////////////////////////////////////
    // stage-1 register
    ////////////////////////////////////////
    always_ff @(posedge i_aclk or negedge i_areset_n) begin
        if (!i_areset_n) begin
            o_round <= '0;
        end else if (i_aclken) begin
            if (i_valid) begin
                o_round.mant  <= sum[fp_convert_pkg::OUT_FRAC_W-1:0];
                o_round.carry <= sum[fp_convert_pkg::OUT_FRAC_W];    // all ones rolled over
            end
        end
    end

endmodule

/* fp_convert/fp_result_pack.sv */
module fp_result_pack (
    input  logic                          i_aclk,
    input  logic                          i_areset_n,
    input  logic                          i_aclken,
    input  fp_convert_pkg::class_bundle_t i_class,
    input  fp_convert_pkg::round_bundle_t i_round,
    output logic                          o_valid,
    output fp_convert_pkg::fp16_t         o_data,
    output logic                          o_overflow,
    output logic                          o_underflow
);

    logic [fp_convert_pkg::IN_EXP_W:0]    exp_sum;
    logic [fp_convert_pkg::OUT_EXP_W-1:0] exp_reb;
    logic                                 is_normal;
    logic                                 under_range;
    logic                                 over_range;
    logic                                 uflow;
    logic                                 oflow;
    fp_convert_pkg::fp16_t                result;

    ////////////////////////////////////////
    // exponent rebias and range
    ////////////////////////////////////////
    always_comb begin
        // input exponent plus the mantissa carry, one bit wider
        exp_sum = {1'b0, i_class.exp}
                + {{fp_convert_pkg::IN_EXP_W{1'b0}}, i_round.carry};

        // exp - 127 + 15, only the low bits survive for in-range values
        exp_reb = (fp_convert_pkg::OUT_EXP_W)'(exp_sum
                - (fp_convert_pkg::IN_BIAS - fp_convert_pkg::OUT_BIAS));

        under_range = (i_class.exp <= (fp_convert_pkg::IN_BIAS - fp_convert_pkg::OUT_BIAS));
        over_range  = (exp_sum >= (fp_convert_pkg::IN_BIAS - fp_convert_pkg::OUT_BIAS
                                  + (2 ** fp_convert_pkg::OUT_EXP_W) - 1));

        is_normal = ~|i_class.cls;
        uflow     = i_class.cls.denorm | (is_normal & under_range);  // no fp16 denormals
        oflow     = is_normal & over_range;
    end

    ////////////////////////////////////////
    // result select
    ////////////////////////////////////////
    always_comb begin
        result      = '0;
        result.sign = i_class.sign;                       // zero for nan already
        if (i_class.cls.zero || uflow) begin
            result.exp  = '0;
            result.frac = '0;
        end else if (i_class.cls.inf || oflow) begin
            result.exp  = '1;
            result.frac = '0;
        end else if (i_class.cls.nan) begin
            result.exp  = '1;
            result.frac = fp_convert_pkg::QNAN_FRAC;      // gives 16'h7e00
        end else begin
            result.exp  = exp_reb;
            result.frac = i_round.mant;
        end
    end

    ////////////////////////////////////////
    // stage-2 register
    ////////////////////////////////////////
    always_ff @(posedge i_aclk or negedge i_areset_n) begin
        if (!i_areset_n) begin
            o_valid     <= 1'b0;
            o_data      <= '0;
            o_overflow  <= 1'b0;
            o_underflow <= 1'b0;
        end else if (i_aclken) begin
            o_valid <= i_class.valid;
            if (i_class.valid) begin                      // hold last result otherwise
                o_data      <= result;
                o_overflow  <= oflow;
                o_underflow <= uflow;
            end
        end
    end

    // range flags come from separate decode paths, they must stay exclusive
    a_flags_exclusive : assert property (
        @(posedge i_aclk) disable iff (!i_areset_n)
        !(o_overflow && o_underflow)
    ) else $error("fp_result_pack: overflow and underflow both set");

endmodule

/* sources.f */
common/fp_convert_pkg.sv
fp_convert/fp_class_decode.sv
fp_convert/fp_mant_round.sv
fp_convert/fp_result_pack.sv
fp_convert/fp32_to_fp16.sv
dv/tb_clk_gen.sv
dv/tb_fp32_to_fp16.sv
